// File: verilog/dcache_pkg.sv
// shared widths and structs for the data cache, imported by every RTL module of it
package dcache_pkg;

	// address split
	localparam int TAG_W = 26;
	localparam int IDX_W = 3;
	localparam int BLK_W = 1;

	// geometry
	localparam int NUM_SETS  = 8;
	localparam int NUM_WAYS  = 2;
	localparam int BLK_WORDS = 2;

	typedef logic [31:0] word_t;

	// byte address as the cache sees it
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic [BLK_W-1:0] blkoff;
		logic [1:0]       bytoff; // always 0 for word accesses
	} dcache_addr_t;

	typedef struct packed {
		logic [TAG_W-1:0]            tag;
		word_t [BLK_WORDS-1:0]       data;
		logic                        valid;
		logic                        dirty;
	} cache_block_t;

	// core side
	typedef struct packed {
		logic  ren;
		logic  wen;
		logic  halt;   // held high once raised
		word_t addr;
		word_t wdata;
	} core_req_t;

	typedef struct packed {
		logic  hit;     // one cycle per accepted request
		word_t rdata;
		logic  flushed; // sticky until reset
	} core_rsp_t;

	// Wishbone classic, cache is master
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat_w;
	} wb_m2s_t;

	typedef struct packed {
		logic  ack;
		word_t dat_r;
	} wb_s2m_t;

endpackage

// File: verilog/dcache_array.sv
`timescale 1ns/10ps
// tag, data, valid/dirty and LRU storage of the cache, with lookup, victim and flush views
module dcache_array
	import dcache_pkg::*;
(
	input  logic             CLK,
	input  logic             nRST,
	input  dcache_addr_t     lookup_addr,
	input  logic             wr_en,
	input  logic             wr_way,
	input  logic             wr_word,
	input  word_t            wr_data,
	input  logic [TAG_W-1:0] wr_tag,
	input  logic             wr_set_valid,
	input  logic             wr_set_dirty,
	input  logic             wr_clr_dirty,
	input  logic             touch,
	input  logic [3:0]       flush_ptr,
	output logic             hit,
	output logic             hit_way,
	output word_t            hit_word,
	output logic             victim_way,
	output cache_block_t     victim_blk,
	output cache_block_t     flush_blk
);

	logic [TAG_W-1:0]    tag_mem  [NUM_SETS][NUM_WAYS];
	word_t               data_mem [NUM_SETS][NUM_WAYS][BLK_WORDS];
	logic [NUM_WAYS-1:0] valid    [NUM_SETS];
	logic [NUM_WAYS-1:0] dirty    [NUM_SETS];
	logic [NUM_SETS-1:0] lru; // way used last in each set

	logic [IDX_W-1:0]    idx;
	logic [NUM_WAYS-1:0] way_match;
	logic [IDX_W-1:0]    fl_idx;
	logic                fl_way;

	assign idx    = lookup_addr.idx;
	assign fl_idx = flush_ptr[3:1]; // two slots per set
	assign fl_way = flush_ptr[0];

	// two-way tag compare
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_match[w] = valid[idx][w] && (tag_mem[idx][w] == lookup_addr.tag);
		end
	end

	assign hit      = |way_match;
	assign hit_way  = way_match[1];
	assign hit_word = data_mem[idx][hit_way][lookup_addr.blkoff];

	// empty way first, otherwise the one not used last
	always_comb begin
		if (!valid[idx][0]) begin
			victim_way = 1'b0;
		end else if (!valid[idx][1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = ~lru[idx];
		end
	end

	always_comb begin
		victim_blk.tag   = tag_mem[idx][victim_way];
		victim_blk.valid = valid[idx][victim_way];
		victim_blk.dirty = dirty[idx][victim_way];
		flush_blk.tag    = tag_mem[fl_idx][fl_way];
		flush_blk.valid  = valid[fl_idx][fl_way];
		flush_blk.dirty  = dirty[fl_idx][fl_way];
		for (int b = 0; b < BLK_WORDS; b++) begin
			victim_blk.data[b] = data_mem[idx][victim_way][b];
			flush_blk.data[b]  = data_mem[fl_idx][fl_way][b];
		end
	end

	// payload
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			tag_mem[idx][wr_way]           <= wr_tag;
			data_mem[idx][wr_way][wr_word] <= wr_data;
		end
	end

	// state bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
			for (int s = 0; s < NUM_SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
			end
		end else begin
			if (wr_en) begin
				if (wr_set_valid) begin
					valid[idx][wr_way] <= 1'b1;
				end
				if (wr_set_dirty) begin
					dirty[idx][wr_way] <= 1'b1;
				end else if (wr_clr_dirty) begin
					dirty[idx][wr_way] <= 1'b0; // fresh block from memory
				end
			end
			if (touch) begin
				lru[idx] <= hit_way;
			end
		end
	end

endmodule

// File: verilog/dcache_ctrl.sv
`timescale 1ns/10ps
// cache FSM for hits, writeback, fill and halt flush; sole Wishbone master of the cache
module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic             CLK,
	input  logic             nRST,
	input  core_req_t        req,
	output core_rsp_t        rsp,
	output wb_m2s_t          wb_o,
	input  wb_s2m_t          wb_i,
	input  logic             hit,
	input  logic             hit_way,
	input  word_t            hit_word,
	input  logic             victim_way,
	input  cache_block_t     victim_blk,
	input  cache_block_t     flush_blk,
	output logic             wr_en,
	output logic             wr_way,
	output logic             wr_word,
	output word_t            wr_data,
	output logic [TAG_W-1:0] wr_tag,
	output logic             wr_set_valid,
	output logic             wr_set_dirty,
	output logic             wr_clr_dirty,
	output logic             touch,
	output logic [3:0]       flush_ptr
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_WB0,
		S_WB1,
		S_FILL0,
		S_FILL1,
		S_FILL_DONE,
		S_FLUSH,
		S_FLUSH_WB0,
		S_FLUSH_WB1,
		S_FLUSHED
	} state_t;

	state_t       state, next_state;
	dcache_addr_t addr;
	logic         access;   // read or write pending
	logic         vway_q;   // victim way, latched at miss
	logic         gap_q;    // forces the idle cycle after an ack
	logic [3:0]   fptr_q, fptr_next;
	logic         bus_req;
	logic         bus_we;
	logic         wsel;     // word number of the current transfer
	logic         ack;

	// memory word address of one block word
	function automatic word_t mem_addr(input logic [TAG_W-1:0] t,
		input logic [IDX_W-1:0] i, input logic w);
		dcache_addr_t a;
		a.tag    = t;
		a.idx    = i;
		a.blkoff = w;
		a.bytoff = 2'b00;
		return word_t'(a);
	endfunction

	assign addr   = dcache_addr_t'(req.addr);
	assign access = (req.ren || req.wen) && !req.halt;

	// Wishbone master
	always_comb begin
		bus_req    = 1'b0;
		bus_we     = 1'b0;
		wsel       = (state == S_WB1) || (state == S_FILL1) || (state == S_FLUSH_WB1);
		wb_o.adr   = '0;
		wb_o.dat_w = '0;
		case (state)
			S_WB0, S_WB1: begin
				bus_req    = 1'b1;
				bus_we     = 1'b1;
				wb_o.adr   = mem_addr(victim_blk.tag, addr.idx, wsel);
				wb_o.dat_w = victim_blk.data[wsel];
			end
			S_FILL0, S_FILL1: begin
				bus_req  = 1'b1;
				wb_o.adr = mem_addr(addr.tag, addr.idx, wsel);
			end
			S_FLUSH_WB0, S_FLUSH_WB1: begin
				bus_req    = 1'b1;
				bus_we     = 1'b1;
				wb_o.adr   = mem_addr(flush_blk.tag, fptr_q[3:1], wsel);
				wb_o.dat_w = flush_blk.data[wsel];
			end
			default: begin
			end
		endcase
		wb_o.cyc = bus_req && !gap_q;
		wb_o.stb = bus_req && !gap_q;
		wb_o.we  = bus_we && !gap_q;
	end

	assign ack = wb_o.cyc && wb_i.ack;

	always_comb begin
		next_state = state;
		fptr_next  = fptr_q;
		case (state)
			S_IDLE: begin
				if (req.halt) begin
					next_state = S_FLUSH;
				end else if (access && !hit) begin
					next_state = (victim_blk.valid && victim_blk.dirty) ? S_WB0 : S_FILL0;
				end
			end
			S_WB0: if (ack) next_state = S_WB1;
			S_WB1: if (ack) next_state = S_FILL0;
			S_FILL0: if (ack) next_state = S_FILL1;
			S_FILL1: if (ack) next_state = S_FILL_DONE;
			S_FILL_DONE: next_state = S_IDLE;
			S_FLUSH: begin
				if (flush_blk.valid && flush_blk.dirty) begin
					next_state = S_FLUSH_WB0;
				end else if (fptr_q == 4'hf) begin
					next_state = S_FLUSHED;
				end else begin
					fptr_next = fptr_q + 4'd1; // clean slot, one cycle
				end
			end
			S_FLUSH_WB0: if (ack) next_state = S_FLUSH_WB1;
			S_FLUSH_WB1: begin
				if (ack) begin
					if (fptr_q == 4'hf) begin
						next_state = S_FLUSHED;
					end else begin
						next_state = S_FLUSH;
						fptr_next  = fptr_q + 4'd1;
					end
				end
			end
			S_FLUSHED: next_state = S_FLUSHED;
			default: next_state = S_IDLE;
		endcase
	end

	// array writes and LRU touch
	always_comb begin
		wr_en        = 1'b0;
		wr_way       = vway_q;
		wr_word      = addr.blkoff;
		wr_data      = req.wdata;
		wr_tag       = addr.tag;
		wr_set_valid = 1'b0;
		wr_set_dirty = 1'b0;
		wr_clr_dirty = 1'b0;
		touch        = 1'b0;
		case (state)
			S_IDLE: begin
				if (access && hit) begin
					touch = 1'b1;
					if (req.wen) begin
						wr_en        = 1'b1;
						wr_way       = hit_way;
						wr_set_dirty = 1'b1;
					end
				end
			end
			S_FILL0, S_FILL1: begin
				if (ack) begin
					wr_en        = 1'b1;
					wr_word      = wsel;
					wr_data      = wb_i.dat_r;
					wr_clr_dirty = 1'b1;
					wr_set_valid = wsel; // valid once both words are in
				end
			end
			S_FILL_DONE: begin
				touch = 1'b1;
				if (req.wen) begin
					wr_en        = 1'b1; // merge the store into the new block
					wr_set_dirty = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	assign rsp.hit     = (state == S_IDLE && access && hit) || (state == S_FILL_DONE);
	assign rsp.rdata   = hit_word;
	assign rsp.flushed = (state == S_FLUSHED);
	assign flush_ptr   = fptr_q;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state  <= S_IDLE;
			fptr_q <= '0;
			vway_q <= 1'b0;
			gap_q  <= 1'b0;
		end else begin
			state  <= next_state;
			fptr_q <= fptr_next;
			gap_q  <= ack;
			if (state == S_IDLE && access && !hit) begin
				vway_q <= victim_way;
			end
		end
	end

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/10ps
// data cache top level, core port on one side and Wishbone master port on the other
module dcache_top
	import dcache_pkg::*;
(
	input  logic      CLK,
	input  logic      nRST,
	input  core_req_t req,
	output core_rsp_t rsp,
	output wb_m2s_t   wb_o,
	input  wb_s2m_t   wb_i
);

	dcache_addr_t     lookup_addr;
	logic             hit;
	logic             hit_way;
	word_t            hit_word;
	logic             victim_way;
	cache_block_t     victim_blk;
	cache_block_t     flush_blk;

	// write command from controller to array
	logic             wr_en;
	logic             wr_way;
	logic             wr_word;
	word_t            wr_data;
	logic [TAG_W-1:0] wr_tag;
	logic             wr_set_valid;
	logic             wr_set_dirty;
	logic             wr_clr_dirty;
	logic             touch;
	logic [3:0]       flush_ptr;

	assign lookup_addr = dcache_addr_t'(req.addr); // lookup always follows the core address

	dcache_array array_i (
		.CLK          (CLK),
		.nRST         (nRST),
		.lookup_addr  (lookup_addr),
		.wr_en        (wr_en),
		.wr_way       (wr_way),
		.wr_word      (wr_word),
		.wr_data      (wr_data),
		.wr_tag       (wr_tag),
		.wr_set_valid (wr_set_valid),
		.wr_set_dirty (wr_set_dirty),
		.wr_clr_dirty (wr_clr_dirty),
		.touch        (touch),
		.flush_ptr    (flush_ptr),
		.hit          (hit),
		.hit_way      (hit_way),
		.hit_word     (hit_word),
		.victim_way   (victim_way),
		.victim_blk   (victim_blk),
		.flush_blk    (flush_blk)
	);

	dcache_ctrl ctrl_i (
		.CLK          (CLK),
		.nRST         (nRST),
		.req          (req),
		.rsp          (rsp),
		.wb_o         (wb_o),
		.wb_i         (wb_i),
		.hit          (hit),
		.hit_way      (hit_way),
		.hit_word     (hit_word),
		.victim_way   (victim_way),
		.victim_blk   (victim_blk),
		.flush_blk    (flush_blk),
		.wr_en        (wr_en),
		.wr_way       (wr_way),
		.wr_word      (wr_word),
		.wr_data      (wr_data),
		.wr_tag       (wr_tag),
		.wr_set_valid (wr_set_valid),
		.wr_set_dirty (wr_set_dirty),
		.wr_clr_dirty (wr_clr_dirty),
		.touch        (touch),
		.flush_ptr    (flush_ptr)
	);

endmodule

// File: dv/wb_mem_model.sv
`timescale 1ns/10ps
// Wishbone classic memory slave for the cache testbench, patterned image and random ack delay
module wb_mem_model
	import dcache_pkg::*;
(
	input  logic    CLK,
	input  logic    nRST,
	input  wb_m2s_t wb_i,
	output wb_s2m_t wb_o
);

	word_t      store[word_t]; // words written so far
	int         delays[256];   // extra wait cycles, one entry per transfer
	logic [7:0] pick;
	int         wait_left;
	logic       busy;

	initial begin
		void'($urandom(13));
		foreach (delays[i]) begin
			delays[i] = int'($urandom % 32'd4);
		end
	end

	// unwritten words keep the fill pattern of their address
	function automatic word_t peek(word_t a);
		if (store.exists(a)) begin
			return store[a];
		end
		return a ^ 32'hA5A50000;
	endfunction

	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_o      <= '0;
			busy      <= 1'b0;
			wait_left <= 0;
			pick      <= '0;
		end else begin
			wb_o.ack <= 1'b0; // ack lasts one cycle
			if (wb_i.cyc && wb_i.stb && !wb_o.ack) begin
				if (!busy) begin
					busy      <= 1'b1;
					wait_left <= delays[pick];
					pick      <= pick + 8'd1;
				end else if (wait_left > 0) begin
					wait_left <= wait_left - 1;
				end else begin
					busy     <= 1'b0;
					wb_o.ack <= 1'b1;
					if (wb_i.we) begin
						store[wb_i.adr] = wb_i.dat_w;
					end else begin
						wb_o.dat_r <= peek(wb_i.adr);
					end
				end
			end
		end
	end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/10ps
// testbench of the data cache, replays the trace file against dcache_top and a memory model
module dcache_tb
	import dcache_pkg::*;
();

	typedef struct packed {
		logic  we;
		word_t adr;
		word_t dat;
	} bus_xfer_t;

	logic      CLK;
	logic      nRST;
	core_req_t req;
	core_rsp_t rsp;
	wb_m2s_t   wb_o;
	wb_s2m_t   wb_i;

	bus_xfer_t xfers[$];       // transfers of the current operation
	word_t     shadow[word_t]; // core view of every store
	bit        dirtied[word_t]; // block bases that took a store
	bit        ack_prev = 1'b0; // ack seen in the previous cycle
	int        errors = 0;
	int        checks = 0;
	int        tests = 0;
	int        test_errs = 0;
	bit        timed_out = 1'b0;
	string     cur_test = "reset_state";

	dcache_top dut_i (.CLK(CLK), .nRST(nRST), .req(req), .rsp(rsp), .wb_o(wb_o), .wb_i(wb_i));
	wb_mem_model mem_i (.CLK(CLK), .nRST(nRST), .wb_i(wb_o), .wb_o(wb_i));

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	// bus monitor, one entry per acked transfer
	always @(negedge CLK) begin
		if (wb_o.cyc && ack_prev) begin
			note_failure("cyc still high in the cycle after an ack");
		end
		ack_prev = wb_o.cyc && wb_o.stb && wb_i.ack;
		if (ack_prev) begin
			xfers.push_back(bus_xfer_t'({wb_o.we, wb_o.adr, wb_o.dat_w}));
		end
	end

	function automatic word_t expect_word(word_t a);
		return shadow.exists(a) ? shadow[a] : (a ^ 32'hA5A50000);
	endfunction

	function automatic void check_val(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0.1f ns: %s got %h expected %h", $realtime, name, got, exp);
			errors++;
			test_errs++;
		end
	endfunction

	function automatic void note_failure(string msg);
		$display("Error at %0.1f ns: %s", $realtime, msg);
		errors++;
		test_errs++;
	endfunction

	function automatic void close_test();
		if (cur_test != "") begin
			$display("test %s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "FAILED",
				test_errs);
			tests++;
		end
		test_errs = 0;
		cur_test  = "";
	endfunction

	function automatic void check_reset();
		check_val("rsp.hit", 32'(rsp.hit), 32'd0);
		check_val("rsp.flushed", 32'(rsp.flushed), 32'd0);
		check_val("wb_o.cyc", 32'(wb_o.cyc), 32'd0);
		check_val("wb_o.stb", 32'(wb_o.stb), 32'd0);
	endfunction

	// hit or flushed, sampled mid-cycle
	task automatic wait_response(input bit for_flush, output word_t data);
		int n;
		bit seen;
		n    = 0;
		seen = 1'b0;
		data = '0;
		while (!seen && n < 200) begin
			@(negedge CLK);
			seen = for_flush ? rsp.flushed : rsp.hit;
			data = rsp.rdata;
			n++;
		end
		if (!seen) begin
			note_failure(for_flush ? "flushed did not rise in 200 cycles" :
				"no hit from the cache in 200 cycles");
			timed_out = 1'b1;
		end
	endtask

	task automatic run_access(string kind, word_t addr, word_t wdata, word_t rdata,
		int nrd, int nwr, word_t wbase);
		word_t got;
		word_t base;
		int    rd;
		int    wr;
		base = {addr[31:3], 3'b000};
		rd   = 0;
		wr   = 0;
		xfers.delete();
		@(posedge CLK);
		#0.5;
		req.ren   = (kind == "R");
		req.wen   = (kind == "W");
		req.addr  = addr;
		req.wdata = wdata;
		wait_response(1'b0, got);
		@(posedge CLK);
		#0.5;
		req.ren = 1'b0;
		req.wen = 1'b0;
		if (timed_out) return;
		if (kind == "R") check_val("rsp.rdata", got, rdata);
		foreach (xfers[i]) begin
			if (xfers[i].we) begin
				if (rd != 0) note_failure("writeback came after the fill reads");
				check_val("wb_o.adr", xfers[i].adr, wbase + 32'(wr * 4));
				check_val("wb_o.dat_w", xfers[i].dat, expect_word(xfers[i].adr));
				wr++;
			end else begin
				check_val("wb_o.adr", xfers[i].adr, base + 32'(rd * 4)); // word 0 then 1
				rd++;
			end
		end
		if (rd != nrd || wr != nwr) begin
			note_failure($sformatf("saw %0d reads and %0d writes, wanted %0d and %0d",
				rd, wr, nrd, nwr));
		end
		if (kind == "W") begin
			shadow[addr]  = wdata;
			dirtied[base] = 1'b1;
		end
	endtask

	task automatic run_halt(int nwr);
		word_t unused;
		xfers.delete();
		@(posedge CLK);
		#0.5;
		req.halt = 1'b1; // held to the end of the run
		wait_response(1'b1, unused);
		if (timed_out) return;
		if (xfers.size() != nwr) begin
			note_failure($sformatf("flush made %0d transfers, wanted %0d", xfers.size(), nwr));
		end
		foreach (xfers[i]) begin
			if (!xfers[i].we) begin
				note_failure("read transfer during the flush");
			end else if (!dirtied.exists({xfers[i].adr[31:3], 3'b000})) begin
				note_failure($sformatf("flush wrote clean block at %h", xfers[i].adr));
			end
			check_val("wb_o.dat_w", xfers[i].dat, expect_word(xfers[i].adr));
		end
	endtask

	initial begin
		int    fd;
		int    cnt;
		string line;
		string tname;
		string kind;
		word_t addr;
		word_t wdata;
		word_t rdata;
		word_t wbase;
		int    nrd;
		int    nwr;
		req  = '0;
		nRST = 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(negedge CLK);
			check_reset();
		end
		@(posedge CLK);
		#0.5;
		nRST = 1'b1;
		@(negedge CLK);
		check_reset(); // first cycle out of reset
		close_test();
		fd = $fopen("dv/dcache_trace.txt", "r");
		if (fd == 0) note_failure("cannot open dv/dcache_trace.txt");
		while (fd != 0 && !timed_out && !$feof(fd)) begin
			cnt = $fgets(line, fd);
			if (cnt == 0 || line.getc(0) == "#") continue;
			cnt = $sscanf(line, "%s %s %h %h %h %d %d %h", tname, kind, addr, wdata, rdata,
				nrd, nwr, wbase);
			if (cnt != 8) continue;
			if (tname != cur_test) begin
				close_test();
				cur_test = tname;
			end
			if (kind == "H") begin
				run_halt(nwr);
			end else if (kind == "M") begin
				check_val($sformatf("mem[%h]", addr), mem_i.peek(addr), rdata);
			end else begin
				run_access(kind, addr, wdata, rdata, nrd, nwr, wbase);
			end
		end
		if (fd != 0) $fclose(fd);
		close_test();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !timed_out && checks > 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: dcache.f
verilog/dcache_pkg.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/wb_mem_model.sv
dv/dcache_tb.sv

// File: Makefile
obj_dir/Vdcache_tb: dcache.f $(shell cat dcache.f)
	verilator --binary --timing --top-module dcache_tb -f dcache.f -o Vdcache_tb

run: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb | tee sim.log
	grep -qx "sim passed" sim.log

check:
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run check clean

// File: dv/dcache_trace.txt
# test kind addr wdata rdata nrd nwr wbase (hex words, nrd/nwr = expected bus reads/writes)
# kind R read, W write, H halt, M memory word after the flush held in the rdata column
cold_miss R 00000100 00000000 a5a50100 2 0 00000000
read_hit R 00000104 00000000 a5a50104 0 0 00000000
write_read W 00000100 11112222 00000000 0 0 00000000
write_read R 00000100 00000000 11112222 0 0 00000000
lru_victim W 00001010 dead0001 00000000 2 0 00000000
lru_victim R 00002014 00000000 a5a52014 2 0 00000000
lru_victim R 00001014 00000000 a5a51014 0 0 00000000
lru_victim R 00003010 00000000 a5a53010 2 0 00000000
lru_victim R 00004010 00000000 a5a54010 2 2 00001010
halt_flush W 00000104 33334444 00000000 0 0 00000000
halt_flush W 00002018 55556666 00000000 2 0 00000000
halt_flush H 00000000 00000000 00000000 0 4 00000000
halt_flush M 00000100 00000000 11112222 0 0 00000000
halt_flush M 00000104 00000000 33334444 0 0 00000000
halt_flush M 00001010 00000000 dead0001 0 0 00000000
halt_flush M 00001014 00000000 a5a51014 0 0 00000000
halt_flush M 00002018 00000000 55556666 0 0 00000000
halt_flush M 0000201c 00000000 a5a5201c 0 0 00000000
halt_flush M 00002010 00000000 a5a52010 0 0 00000000
halt_flush M 00004014 00000000 a5a54014 0 0 00000000
halt_flush M 00000108 00000000 a5a50108 0 0 00000000
